//--- bench/rvc_properties.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_properties (
	input logic                 clk_i,
	input logic                 rst_n_i,
	input logic                 in_valid_i,
	input logic [`RVC_ILEN-1:0] instr_i,
	input logic                 out_valid_i,
	input logic [`RVC_ILEN-1:0] out_instr_i,
	input logic                 out_comp_i,
	input logic                 out_sigill_i
);
	int unsigned err_count = 0;

	// two register stages between a strobe and its result
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		in_valid_i |-> ##2 out_valid_i)
	else begin
		$error("no out_valid two cycles after a strobe");
		err_count++;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_i |-> $past(in_valid_i, 2))
	else begin
		$error("out_valid without a strobe two cycles earlier");
		err_count++;
	end

	assert property (@(posedge clk_i)
		(!rst_n_i || $rose(rst_n_i)) |-> (!out_valid_i && !out_sigill_i))
	else begin
		$error("outputs active during or right after reset");
		err_count++;
	end

	// full-width words pass through untouched
	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(in_valid_i && instr_i[1:0] == 2'b11) |->
		##2 (out_instr_i == $past(instr_i, 2) && !out_comp_i && !out_sigill_i))
	else begin
		$error("uncompressed word was not passed through");
		err_count++;
	end

	assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(in_valid_i && instr_i[`RVC_CLEN-1:0] == '0) |->
		##2 (out_sigill_i && out_instr_i == '0))
	else begin
		$error("all-zero parcel did not raise sigill");
		err_count++;
	end
endmodule

bind rvc_decompressor rvc_properties u_props (
	.clk_i        (clk_i),
	.rst_n_i      (rst_n_i),
	.in_valid_i   (in_valid_i),
	.instr_i      (instr_i),
	.out_valid_i  (out_valid_o),
	.out_instr_i  (instr_o),
	.out_comp_i   (is_compressed_o),
	.out_sigill_i (sigill_o)
);

`default_nettype wire

//--- bench/rvc_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_tb;
	localparam int reset_cycles = 3;
	localparam int n_random     = 40;
	localparam int latency      = 2;

	logic                 clk_i;
	logic                 rst_n_i;
	logic                 in_valid_i;
	logic [`RVC_ILEN-1:0] instr_i;
	logic                 out_valid_o;
	logic [`RVC_ILEN-1:0] instr_o;
	logic                 is_compressed_o;
	logic                 sigill_o;

	logic [`RVC_CLEN-1:0] vec_in[$];
	logic [`RVC_ILEN-1:0] vec_exp[$];
	logic                 vec_ill[$];
	// results still in flight
	logic [`RVC_ILEN-1:0] exp_word[$];
	logic                 exp_ill[$];
	logic                 exp_comp[$];
	logic [`RVC_ILEN-1:0] rand_word;
	integer               seed;
	int                   cycles;
	int                   max_cycles;

	rvc_decompressor DUT (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.in_valid_i      (in_valid_i),
		.instr_i         (instr_i),
		.out_valid_o     (out_valid_o),
		.instr_o         (instr_o),
		.is_compressed_o (is_compressed_o),
		.sigill_o        (sigill_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	task automatic report_failure();
		$display("Done: errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			report_failure();
		end
	endtask

	task automatic add_vector(input logic [15:0] c, input logic [31:0] exp, input logic ill);
		vec_in.push_back(c);
		vec_exp.push_back(exp);
		vec_ill.push_back(ill);
	endtask

	task automatic send_word(input logic [31:0] word, input logic [31:0] exp, input logic ill);
		@(negedge clk_i);
		in_valid_i = 1'b1;
		instr_i    = word;
		exp_word.push_back(exp);
		exp_ill.push_back(ill);
		exp_comp.push_back(word[1:0] != 2'b11);
	endtask

	task automatic load_table();
		// quadrant 0
		add_vector(16'h1ffc, 32'h3fc10793, 1'b0);
		add_vector(16'h4144, 32'h00452483, 1'b0);
		add_vector(16'hc60c, 32'h00b62423, 1'b0);
		// quadrant 1
		add_vector(16'h12f5, 32'hffd28293, 1'b0);
		add_vector(16'h433d, 32'h00f00313, 1'b0);
		add_vector(16'h3ffd, 32'hfffff0ef, 1'b0);
		add_vector(16'hac15, 32'h2340006f, 1'b0);
		add_vector(16'h7139, 32'hfc010113, 1'b0);
		add_vector(16'h77fd, 32'hfffff7b7, 1'b0);
		add_vector(16'h800d, 32'h00345413, 1'b0);
		add_vector(16'h84fd, 32'h41f4d493, 1'b0);
		add_vector(16'h997d, 32'hfff57513, 1'b0);
		add_vector(16'h8c05, 32'h40940433, 1'b0);
		add_vector(16'h8db1, 32'h00c5c5b3, 1'b0);
		add_vector(16'h8ed9, 32'h00e6e6b3, 1'b0);
		add_vector(16'h8fe1, 32'h0087f7b3, 1'b0);
		add_vector(16'hc401, 32'h00040463, 1'b0);
		add_vector(16'hfcfd, 32'hfe049fe3, 1'b0);
		// quadrant 2
		add_vector(16'h0396, 32'h00539393, 1'b0);
		add_vector(16'h40b2, 32'h00c12083, 1'b0);
		add_vector(16'hc606, 32'h00112623, 1'b0);
		add_vector(16'h8282, 32'h00028067, 1'b0);
		add_vector(16'h9302, 32'h000300e7, 1'b0);
		add_vector(16'h852e, 32'h00b00533, 1'b0);
		add_vector(16'h9636, 32'h00d60633, 1'b0);
		add_vector(16'h9002, 32'h00100073, 1'b0);
		// zero, c.flw, c.fswsp, c.subw, reserved alu op, c.jr x0
		add_vector(16'h0000, 32'h00000000, 1'b1);
		add_vector(16'h6144, 32'h00000000, 1'b1);
		add_vector(16'he006, 32'h00000000, 1'b1);
		add_vector(16'h9c05, 32'h00000000, 1'b1);
		add_vector(16'h9c45, 32'h00000000, 1'b1);
		add_vector(16'h8002, 32'h00000000, 1'b1);
	endtask

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk_i) begin
		if (rst_n_i && out_valid_o) begin
			if (exp_word.size() == 0) begin
				$display("out_valid_o was high at %0t with no word in flight", $time);
				report_failure();
			end else begin
				check_value("instr_o", instr_o, exp_word.pop_front());
				check_value("sigill_o", sigill_o, exp_ill.pop_front());
				check_value("is_compressed_o", is_compressed_o, exp_comp.pop_front());
			end
		end
		if (DUT.u_props.err_count != 0) begin
			$display("a bound timing, reset or passthrough assertion failed at %0t", $time);
			report_failure();
		end
	end

	always @(posedge clk_i) begin
		cycles = cycles + 1;
		if (cycles > max_cycles) begin
			$display("timeout after %0d cycles, outputs stopped arriving", cycles);
			report_failure();
		end
	end

	initial begin
		rst_n_i    = 1'b1;
		in_valid_i = 1'b0;
		instr_i    = '0;
		seed       = 64788;
		cycles     = 0;
		load_table();
		max_cycles = reset_cycles + vec_in.size() + n_random + latency + 20;
		#1;
		rst_n_i = 1'b0;
		repeat (reset_cycles) @(negedge clk_i);
		rst_n_i = 1'b1;
		foreach (vec_in[i]) begin
			send_word({16'h0000, vec_in[i]}, vec_exp[i], vec_ill[i]);
		end
		repeat (n_random) begin
			rand_word      = $random(seed);
			rand_word[1:0] = 2'b11;
			send_word(rand_word, rand_word, 1'b0);
		end
		@(negedge clk_i);
		in_valid_i = 1'b0;
		while (exp_word.size() != 0) begin
			@(negedge clk_i);
		end
		repeat (2) @(negedge clk_i);
		if (DUT.u_props.err_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "bound assertions reported failures");
		end
	end
endmodule

`default_nettype wire

//--- design/rvc_cfg.svh
`ifndef RVC_CFG_SVH
`define RVC_CFG_SVH

// base and compressed instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

`define RVC_REG_W 5

// fixed registers used by the stack and link forms
`define RVC_SP_REG 5'd2
`define RVC_RA_REG 5'd1

`endif

//--- design/rvc_decompressor.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_decompressor (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 in_valid_i,
	input  logic [`RVC_ILEN-1:0] instr_i,
	output logic                 out_valid_o,
	output logic [`RVC_ILEN-1:0] instr_o,
	output logic                 is_compressed_o,
	output logic                 sigill_o
);
	rvc_predec_if pd_if ();
	rvc_fields_if fl_if ();

	// fetch word register and class
	rvc_predecode u_predecode (
		.clk_i      (clk_i),
		.rst_n_i    (rst_n_i),
		.in_valid_i (in_valid_i),
		.instr_i    (instr_i),
		.pd_o       (pd_if.src)
	);

	rvc_expander u_expander (
		.pd_i (pd_if.dst),
		.fl_o (fl_if.src)
	);

	// field packing and output register
	rvc_encoder u_encoder (
		.clk_i           (clk_i),
		.rst_n_i         (rst_n_i),
		.fl_i            (fl_if.dst),
		.out_valid_o     (out_valid_o),
		.instr_o         (instr_o),
		.is_compressed_o (is_compressed_o),
		.sigill_o        (sigill_o)
	);
endmodule

`default_nettype wire

//--- design/rvc_encoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_encoder (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	rvc_fields_if.dst            fl_i,
	output logic                 out_valid_o,
	output logic [`RVC_ILEN-1:0] instr_o,
	output logic                 is_compressed_o,
	output logic                 sigill_o
);
	import rvc_pkg::*;

	logic [`RVC_ILEN-1:0] word;

	always_comb begin
		case (fl_i.fmt)
			// raw shares the r layout bit for bit
			fmt_r, fmt_raw: begin
				word = {fl_i.funct7, fl_i.rs2, fl_i.rs1, fl_i.funct3, fl_i.rd, fl_i.opcode, 2'b11};
			end
			fmt_i: begin
				word = {fl_i.imm[11:0], fl_i.rs1, fl_i.funct3, fl_i.rd, fl_i.opcode, 2'b11};
			end
			fmt_s: begin
				word = {fl_i.imm[11:5], fl_i.rs2, fl_i.rs1, fl_i.funct3, fl_i.imm[4:0],
					fl_i.opcode, 2'b11};
			end
			// imm is offset[12:1]
			fmt_b: begin
				word = {fl_i.imm[11], fl_i.imm[9:4], fl_i.rs2, fl_i.rs1, fl_i.funct3,
					fl_i.imm[3:0], fl_i.imm[10], fl_i.opcode, 2'b11};
			end
			fmt_u: begin
				word = {fl_i.imm, fl_i.rd, fl_i.opcode, 2'b11};
			end
			// imm is offset[20:1]
			fmt_j: begin
				word = {fl_i.imm[19], fl_i.imm[9:0], fl_i.imm[10], fl_i.imm[18:11],
					fl_i.rd, fl_i.opcode, 2'b11};
			end
			default: begin
				word = '0;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			out_valid_o     <= 1'b0;
			instr_o         <= '0;
			is_compressed_o <= 1'b0;
			sigill_o        <= 1'b0;
		end else begin
			out_valid_o <= fl_i.valid;
			sigill_o    <= fl_i.valid & fl_i.illegal;
			if (fl_i.valid) begin
				instr_o         <= fl_i.illegal ? '0 : word;
				is_compressed_o <= fl_i.is_compressed;
			end
		end
	end
endmodule

`default_nettype wire

//--- design/rvc_expander.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_expander (
	rvc_predec_if.dst pd_i,
	rvc_fields_if.src fl_o
);
	import rvc_pkg::*;

	logic [`RVC_CLEN-1:0]  c;
	logic [`RVC_ILEN-1:0]  w;
	logic [`RVC_REG_W-1:0] rd_p;
	logic [`RVC_REG_W-1:0] rs1_p;
	logic [`RVC_REG_W-1:0] rd_full;
	logic [19:0]           imm6_sx;
	logic [19:0]           jmp_off;
	logic [19:0]           br_off;

	assign w = pd_i.instr;
	assign c = pd_i.instr[`RVC_CLEN-1:0];

	// 3-bit register fields select x8..x15
	assign rd_p    = {2'b01, c[4:2]};
	assign rs1_p   = {2'b01, c[9:7]};
	assign rd_full = c[11:7];

	assign imm6_sx = {{14{c[12]}}, c[12], c[6:2]};
	// offset[20:1] of c.j / c.jal
	assign jmp_off = {{9{c[12]}}, c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3]};
	// offset[12:1] of c.beqz / c.bnez
	assign br_off  = {{12{c[12]}}, c[12], c[6:5], c[2], c[11:10], c[4:3]};

	assign fl_o.valid         = pd_i.valid;
	assign fl_o.is_compressed = pd_i.is_compressed;

	always_comb begin
		fl_o.illegal = 1'b0;
		fl_o.fmt     = fmt_i;
		fl_o.opcode  = op_opimm;
		fl_o.rd      = '0;
		fl_o.rs1     = '0;
		fl_o.rs2     = '0;
		fl_o.funct3  = 3'b000;
		fl_o.funct7  = 7'b0000000;
		fl_o.imm     = '0;

		case (pd_i.group)
			grp_uncomp: begin
				fl_o.fmt    = fmt_raw;
				fl_o.opcode = rv_opcode_e'(w[6:2]);
				fl_o.rd     = w[11:7];
				fl_o.funct3 = w[14:12];
				fl_o.rs1    = w[19:15];
				fl_o.rs2    = w[24:20];
				fl_o.funct7 = w[31:25];
			end
			grp_q0_addi4spn: begin
				fl_o.rd  = rd_p;
				fl_o.rs1 = `RVC_SP_REG;
				fl_o.imm = {10'b0, c[10:7], c[12:11], c[5], c[6], 2'b00};
			end
			grp_q0_lw: begin
				fl_o.opcode = op_load;
				fl_o.rd     = rd_p;
				fl_o.rs1    = rs1_p;
				fl_o.funct3 = 3'b010;
				fl_o.imm    = {13'b0, c[5], c[12:10], c[6], 2'b00};
			end
			grp_q0_sw: begin
				fl_o.fmt    = fmt_s;
				fl_o.opcode = op_store;
				fl_o.rs1    = rs1_p;
				fl_o.rs2    = rd_p;
				fl_o.funct3 = 3'b010;
				fl_o.imm    = {13'b0, c[5], c[12:10], c[6], 2'b00};
			end
			grp_q1_addi: begin
				fl_o.rd  = rd_full;
				fl_o.rs1 = rd_full;
				fl_o.imm = imm6_sx;
			end
			grp_q1_li: begin
				fl_o.rd  = rd_full;
				fl_o.imm = imm6_sx;
			end
			grp_q1_jal, grp_q1_j: begin
				fl_o.fmt    = fmt_j;
				fl_o.opcode = op_jal;
				fl_o.rd     = c[15] ? '0 : `RVC_RA_REG;
				fl_o.imm    = jmp_off;
			end
			grp_q1_lui: begin
				// rd of sp selects addi16sp
				if (rd_full == `RVC_SP_REG) begin
					fl_o.rd  = `RVC_SP_REG;
					fl_o.rs1 = `RVC_SP_REG;
					fl_o.imm = {{10{c[12]}}, c[12], c[4:3], c[5], c[2], c[6], 4'b0000};
				end else begin
					fl_o.fmt    = fmt_u;
					fl_o.opcode = op_lui;
					fl_o.rd     = rd_full;
					fl_o.imm    = imm6_sx;
				end
			end
			grp_q1_alu: begin
				fl_o.rd  = rs1_p;
				fl_o.rs1 = rs1_p;
				case (c[11:10])
					2'b00, 2'b01: begin
						fl_o.funct3 = 3'b101;
						fl_o.imm    = {9'b0, c[10], 4'b0000, c[12], c[6:2]};
					end
					2'b10: begin
						fl_o.funct3 = 3'b111;
						fl_o.imm    = imm6_sx;
					end
					default: begin
						// c[12] set is the rv64 word ops or reserved
						fl_o.illegal = c[12];
						fl_o.fmt     = fmt_r;
						fl_o.opcode  = op_op;
						fl_o.rs2     = rd_p;
						fl_o.funct3  = {|c[6:5], c[6], &c[6:5]};
						fl_o.funct7  = {1'b0, ~|c[6:5], 5'b00000};
					end
				endcase
			end
			grp_q1_beqz, grp_q1_bnez: begin
				fl_o.fmt    = fmt_b;
				fl_o.opcode = op_branch;
				fl_o.rs1    = rs1_p;
				fl_o.funct3 = {2'b00, c[13]};
				fl_o.imm    = br_off;
			end
			grp_q2_slli: begin
				fl_o.rd     = rd_full;
				fl_o.rs1    = rd_full;
				fl_o.funct3 = 3'b001;
				fl_o.imm    = {14'b0, c[12], c[6:2]};
			end
			grp_q2_lwsp: begin
				fl_o.opcode = op_load;
				fl_o.rd     = rd_full;
				fl_o.rs1    = `RVC_SP_REG;
				fl_o.funct3 = 3'b010;
				fl_o.imm    = {12'b0, c[3:2], c[12], c[6:4], 2'b00};
			end
			grp_q2_misc: begin
				// ebreak, then rs1 zero, then jr/jalr, then mv/add
				if (c[12] && rd_full == '0 && c[6:2] == '0) begin
					fl_o.opcode = op_system;
					fl_o.imm    = 20'd1;
				end else if (rd_full == '0 && c[6:2] == '0) begin
					fl_o.illegal = 1'b1;
				end else if (c[6:2] == '0) begin
					fl_o.opcode = op_jalr;
					fl_o.rd     = c[12] ? `RVC_RA_REG : '0;
					fl_o.rs1    = rd_full;
				end else begin
					fl_o.fmt    = fmt_r;
					fl_o.opcode = op_op;
					fl_o.rd     = rd_full;
					fl_o.rs1    = c[12] ? rd_full : '0;
					fl_o.rs2    = c[6:2];
				end
			end
			grp_q2_swsp: begin
				fl_o.fmt    = fmt_s;
				fl_o.opcode = op_store;
				fl_o.rs1    = `RVC_SP_REG;
				fl_o.rs2    = c[6:2];
				fl_o.funct3 = 3'b010;
				fl_o.imm    = {12'b0, c[8:7], c[12:9], 2'b00};
			end
			// all-zero word, reserved slot, fp loads and stores
			default: begin
				fl_o.illegal = 1'b1;
			end
		endcase
	end
endmodule

`default_nettype wire

//--- design/rvc_if.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

interface rvc_predec_if;
	import rvc_pkg::*;

	logic                 valid;
	logic [`RVC_ILEN-1:0] instr;
	logic                 is_compressed;
	rvc_group_e           group;

	modport src (output valid, output instr, output is_compressed, output group);
	modport dst (input valid, input instr, input is_compressed, input group);
endinterface

interface rvc_fields_if;
	import rvc_pkg::*;

	logic                  valid;
	logic                  illegal;
	logic                  is_compressed;
	rv_format_e            fmt;
	rv_opcode_e            opcode;
	logic [`RVC_REG_W-1:0] rd;
	logic [`RVC_REG_W-1:0] rs1;
	logic [`RVC_REG_W-1:0] rs2;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	// layout depends on fmt
	logic [19:0]           imm;

	modport src (
		output valid, output illegal, output is_compressed, output fmt, output opcode,
		output rd, output rs1, output rs2, output funct3, output funct7, output imm
	);
	modport dst (
		input valid, input illegal, input is_compressed, input fmt, input opcode,
		input rd, input rs1, input rs2, input funct3, input funct7, input imm
	);
endinterface

`default_nettype wire

//--- design/rvc_pkg.sv
`default_nettype none

package rvc_pkg;

	// major opcode, bits 6:2 of the base word
	typedef enum logic [4:0] {
		op_load   = 5'b00000,
		op_opimm  = 5'b00100,
		op_store  = 5'b01000,
		op_op     = 5'b01100,
		op_lui    = 5'b01101,
		op_branch = 5'b11000,
		op_jalr   = 5'b11001,
		op_jal    = 5'b11011,
		op_system = 5'b11100
	} rv_opcode_e;

	// raw packs the upper 30 bits of an uncompressed word unchanged
	typedef enum logic [2:0] {
		fmt_r,
		fmt_i,
		fmt_s,
		fmt_b,
		fmt_u,
		fmt_j,
		fmt_raw
	} rv_format_e;

	// {quadrant, funct3}
	typedef enum logic [4:0] {
		grp_q0_addi4spn = 5'b00000,
		grp_q0_fld      = 5'b00001,
		grp_q0_lw       = 5'b00010,
		grp_q0_flw      = 5'b00011,
		grp_q0_rsv      = 5'b00100,
		grp_q0_fsd      = 5'b00101,
		grp_q0_sw       = 5'b00110,
		grp_q0_fsw      = 5'b00111,
		grp_q1_addi     = 5'b01000,
		grp_q1_jal      = 5'b01001,
		grp_q1_li       = 5'b01010,
		grp_q1_lui      = 5'b01011,
		grp_q1_alu      = 5'b01100,
		grp_q1_j        = 5'b01101,
		grp_q1_beqz     = 5'b01110,
		grp_q1_bnez     = 5'b01111,
		grp_q2_slli     = 5'b10000,
		grp_q2_fldsp    = 5'b10001,
		grp_q2_lwsp     = 5'b10010,
		grp_q2_flwsp    = 5'b10011,
		grp_q2_misc     = 5'b10100,
		grp_q2_fsdsp    = 5'b10101,
		grp_q2_swsp     = 5'b10110,
		grp_q2_fswsp    = 5'b10111,
		grp_uncomp      = 5'b11000,
		grp_zero        = 5'b11111
	} rvc_group_e;

endpackage

`default_nettype wire

//--- design/rvc_predecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "rvc_cfg.svh"

module rvc_predecode (
	input  logic                 clk_i,
	input  logic                 rst_n_i,
	input  logic                 in_valid_i,
	input  logic [`RVC_ILEN-1:0] instr_i,
	rvc_predec_if.src            pd_o
);
	import rvc_pkg::*;

	logic                 valid_q;
	logic [`RVC_ILEN-1:0] instr_q;
	logic                 compressed;
	rvc_group_e           group;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (in_valid_i) begin
			instr_q <= instr_i;
		end
	end

	// low bits 11 mean a full 32-bit word
	assign compressed = ~&instr_q[1:0];

	always_comb begin
		if (instr_q[`RVC_CLEN-1:0] == '0) begin
			group = grp_zero;
		end else if (!compressed) begin
			group = grp_uncomp;
		end else begin
			group = rvc_group_e'({instr_q[1:0], instr_q[15:13]});
		end
	end

	assign pd_o.valid         = valid_q;
	assign pd_o.instr         = instr_q;
	assign pd_o.is_compressed = compressed;
	assign pd_o.group         = group;
endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/rvc_pkg.sv
design/rvc_if.sv
design/rvc_predecode.sv
design/rvc_expander.sv
design/rvc_encoder.sv
design/rvc_decompressor.sv
bench/rvc_properties.sv
bench/rvc_tb.sv
